// File: reorderBuffer.f
+incdir+common
common/robPkg.sv
rob/robEntryStore.sv
rob/robHeadCounter.sv
rob/robCommitCtrl.sv
verilog/reorderBuffer.sv
test/reorderBufferTb.sv

// File: Makefile
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f reorderBuffer.f \
		--top-module reorderBufferTb -Mdir obj_dir

run: build
	./obj_dir/VreorderBufferTb | tee $(LOG)
	grep -q "all tests passed" $(LOG)

lint:
	verilator --lint-only --timing -f reorderBuffer.f --top-module reorderBufferTb
	verilator --lint-only +incdir+common common/robPkg.sv rob/robEntryStore.sv \
		rob/robHeadCounter.sv rob/robCommitCtrl.sv verilog/reorderBuffer.sv \
		--top-module reorderBuffer

clean:
	rm -rf obj_dir $(LOG)

// File: test/reorderBufferTb.sv
`include "rob_defines.svh"

module reorderBufferTb;
    timeunit 1ns;
    timeprecision 1ps;
    import robPkg::*;

    localparam int NUM_TESTS = 6;
    localparam logic [31:0] IRQ_ADDR = 32'h0000_0800;

    logic clk;
    logic rst;
    logic wbValid [`WB_WIDTH];
    SqN wbSqN [`WB_WIDTH];
    Flags wbFlags [`WB_WIDTH];
    logic [6:0] wbTag [`WB_WIDTH];
    logic [5:0] wbName [`WB_WIDTH];
    logic [31:0] wbPc [`WB_WIDTH];
    logic wbIsBranch [`WB_WIDTH];
    logic wbBranchTaken [`WB_WIDTH];
    BrId wbBranchId [`WB_WIDTH];
    logic invalidate;
    SqN invalidateSqN;
    logic [31:0] irqAddr;
    SqN curSqN;
    SqN maxSqN;
    logic [31:0] retiredCount;
    logic comValid [`COMMIT_WIDTH];
    SqN comSqN [`COMMIT_WIDTH];
    logic [5:0] comName [`COMMIT_WIDTH];
    logic [6:0] comTag [`COMMIT_WIDTH];
    logic [31:0] comPc [`COMMIT_WIDTH];
    logic comIsBranch [`COMMIT_WIDTH];
    logic comBranchTaken [`COMMIT_WIDTH];
    BrId comBranchId [`COMMIT_WIDTH];
    logic redirectValid;
    logic [31:0] redirectPc;
    SqN redirectSqN;
    logic halt;
    logic fence;
    Flags irqFlags;
    logic [31:0] irqSrc;
    logic [31:0] irqMemAddr;

    // reference model of written entries, indexed by the full sqN
    logic expValid [64];
    Flags expFlags [64];
    logic [5:0] expName [64];
    logic [6:0] expTag [64];
    logic [31:0] expPc [64];
    logic expBranch [64];
    BrId expBrId [64];
    SqN nextSqN;
    logic [5:0] salt;
    int seed = 32'h1047;
    int errors, testsRun, testsBad;
    int tripleCount, singleCount, haltCount, fenceCount, irqCount;

    reorderBuffer i_reorderBuffer (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * 200 * 8);
        $display("watchdog expired before the tests completed");
        $display("tests failed");
        $finish;
    end

    task automatic expectEq(input string sigName, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got %h expected %h", sigName, got, exp);
            errors++;
        end
    endtask

    // payload fields are derived from sqN and the current salt
    task automatic putLane(input int lane, input SqN s, input Flags f, input logic br);
        logic [5:0] nm;
        nm = s ^ salt;
        wbValid[lane] <= 1'b1;
        wbSqN[lane] <= s;
        wbFlags[lane] <= f;
        wbName[lane] <= nm;
        wbTag[lane] <= {1'b1, nm};
        wbPc[lane] <= 32'h1000 + 32'(s) * 4;
        wbIsBranch[lane] <= br;
        wbBranchTaken[lane] <= s[0];
        wbBranchId[lane] <= 8'h40 + 8'(s);
        expValid[s] = 1'b1;
        expFlags[s] = f;
        expName[s] = nm;
        expTag[s] = {1'b1, nm};
        expPc[s] = 32'h1000 + 32'(s) * 4;
        expBranch[s] = br;
        expBrId[s] = 8'h40 + 8'(s);
    endtask

    task automatic clearLanes();
        for (int i = 0; i < `WB_WIDTH; i++) begin
            wbValid[i] <= 1'b0;
        end
        invalidate <= 1'b0;
    endtask

    task automatic waitRetired(input int target);
        int n;
        n = 0;
        while (retiredCount < target && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (retiredCount < target) begin
            $display("timed out waiting for %0d instructions to retire", target);
            errors++;
        end
    endtask

    task automatic finishTest(input string testName, input int errBefore);
        testsRun++;
        if (errors == errBefore) begin
            $display("test %s: ok", testName);
        end else begin
            testsBad++;
            $display("test %s: FAIL with %0d errors", testName, errors - errBefore);
        end
    endtask

    // compare one commit lane with the next in-order entry of the model
    task automatic checkLane(input int i);
        SqN s;
        Flags f;
        s = nextSqN;
        f = expFlags[s];
        assert (expValid[s]) else begin
            $display("commit of sqN %h which was never written or was squashed", s);
            errors++;
        end
        expectEq("comSqN", comSqN[i], s);
        expectEq("comName", comName[i],
            (f == FLAGS_BRK || f == FLAGS_EXCEPT) ? 6'd0 : expName[s]);
        expectEq("comTag", comTag[i], expTag[s]);
        expectEq("comPc", comPc[i], expPc[s]);
        expectEq("comIsBranch", comIsBranch[i], expBranch[s]);
        expectEq("comBranchTaken", comBranchTaken[i], s[0]);
        expectEq("comBranchId", comBranchId[i], expBrId[s]);
        if (i == 0) begin
            expectEq("redirectValid", redirectValid, f != FLAGS_NONE);
            expectEq("halt", halt, f == FLAGS_BRK);
            expectEq("fence", fence, f == FLAGS_FENCE);
            if (f != FLAGS_NONE) begin
                expectEq("redirectSqN", redirectSqN, s);
            end
            if (f == FLAGS_TRAP || f == FLAGS_EXCEPT) begin
                expectEq("redirectPc", redirectPc, IRQ_ADDR);
                expectEq("irqFlags", irqFlags, f);
                expectEq("irqSrc", irqSrc, expPc[s]);
                expectEq("irqMemAddr", irqMemAddr,
                    {7'b0, expName[s], s[0], expBrId[s], 10'b0});
                irqCount++;
            end else if (f != FLAGS_NONE) begin
                expectEq("redirectPc", redirectPc, expPc[s] + 32'd4);
                if (f == FLAGS_BRK) haltCount++;
                else fenceCount++;
            end
        end
        expValid[s] = 1'b0;
        nextSqN = nextSqN + 1'b1;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            assert (comValid[1] == comValid[2] && (!comValid[1] || comValid[0])) else begin
                $display("commit lanes valid in a pattern other than one or three");
                errors++;
            end
            if (comValid[0] && comValid[2]) tripleCount++;
            else if (comValid[0]) singleCount++;
            if (!comValid[0]) begin
                expectEq("redirectValid", redirectValid, 1'b0);
                expectEq("halt", halt, 1'b0);
                expectEq("fence", fence, 1'b0);
            end
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                if (comValid[i]) checkLane(i);
            end
        end
    end

    initial begin
        int e, t, s0, j;
        SqN order [3];
        SqN tmp;
        rst = 1'b1;
        invalidate = 1'b0;
        invalidateSqN = '0;
        irqAddr = IRQ_ADDR;
        for (int i = 0; i < `WB_WIDTH; i++) begin
            wbValid[i] = 1'b0;
            wbSqN[i] = '0;
            wbFlags[i] = FLAGS_NONE;
            wbTag[i] = '0;
            wbName[i] = '0;
            wbPc[i] = '0;
            wbIsBranch[i] = 1'b0;
            wbBranchTaken[i] = 1'b0;
            wbBranchId[i] = '0;
        end
        for (int i = 0; i < 64; i++) expValid[i] = 1'b0;
        nextSqN = '0;
        salt = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        e = errors;
        @(negedge clk);
        for (int i = 0; i < `COMMIT_WIDTH; i++) expectEq("comValid", comValid[i], 1'b0);
        expectEq("curSqN", curSqN, 6'd0);
        expectEq("maxSqN", maxSqN, 6'd31);
        expectEq("retiredCount", retiredCount, 32'd0);
        finishTest("reset", e);

        // two groups of three, lanes shuffled within each group
        e = errors;
        t = tripleCount;
        for (int g = 0; g < 2; g++) begin
            @(posedge clk);
            for (int k = 0; k < 3; k++) order[k] = SqN'(g * 3 + k);
            for (int k = 2; k > 0; k--) begin
                j = $unsigned($random(seed)) % (k + 1);
                tmp = order[k];
                order[k] = order[j];
                order[j] = tmp;
            end
            for (int k = 0; k < 3; k++) putLane(k, order[k], FLAGS_NONE, 1'b0);
        end
        @(posedge clk);
        clearLanes();
        waitRetired(6);
        @(negedge clk);
        expectEq("tripleCount", tripleCount - t, 2);
        expectEq("curSqN", curSqN, 6'd6);
        finishTest("triple retire", e);

        // a branch in slot 1 then a short window force single commits
        e = errors;
        t = tripleCount;
        s0 = singleCount;
        @(posedge clk);
        putLane(0, 6'd6, FLAGS_NONE, 1'b0);
        putLane(1, 6'd7, FLAGS_NONE, 1'b1);
        putLane(2, 6'd8, FLAGS_NONE, 1'b0);
        @(posedge clk);
        clearLanes();
        waitRetired(9);
        @(negedge clk);
        expectEq("tripleCount", tripleCount - t, 0);
        expectEq("singleCount", singleCount - s0, 3);
        finishTest("single retire", e);

        e = errors;
        t = irqCount;
        @(posedge clk);
        putLane(0, 6'd9, FLAGS_TRAP, 1'b0);
        putLane(1, 6'd10, FLAGS_EXCEPT, 1'b0);
        @(posedge clk);
        clearLanes();
        waitRetired(11);
        @(negedge clk);
        expectEq("irqCount", irqCount - t, 2);
        expectEq("irqFlags", irqFlags, FLAGS_EXCEPT);
        finishTest("trap and exception", e);

        e = errors;
        t = haltCount;
        s0 = fenceCount;
        @(posedge clk);
        putLane(2, 6'd11, FLAGS_BRK, 1'b0);
        putLane(0, 6'd12, FLAGS_FENCE, 1'b0);
        @(posedge clk);
        clearLanes();
        waitRetired(13);
        @(negedge clk);
        expectEq("haltCount", haltCount - t, 1);
        expectEq("fenceCount", fenceCount - s0, 1);
        finishTest("breakpoint and fence", e);

        // head waits on sqN 13 while younger entries sit in the buffer
        e = errors;
        @(posedge clk);
        putLane(0, 6'd14, FLAGS_NONE, 1'b0);
        putLane(1, 6'd15, FLAGS_NONE, 1'b0);
        putLane(2, 6'd16, FLAGS_NONE, 1'b0);
        @(posedge clk);
        clearLanes();
        invalidate <= 1'b1;
        invalidateSqN <= 6'd14;
        putLane(0, 6'd13, FLAGS_NONE, 1'b0);
        putLane(1, 6'd17, FLAGS_NONE, 1'b0);
        expValid[15] = 1'b0;
        expValid[16] = 1'b0;
        expValid[17] = 1'b0;
        @(posedge clk);
        clearLanes();
        waitRetired(15);
        repeat (6) @(negedge clk);
        expectEq("retiredCount", retiredCount, 32'd15);
        expectEq("curSqN", curSqN, 6'd15);
        @(posedge clk);
        salt = 6'h2a;
        putLane(0, 6'd15, FLAGS_NONE, 1'b0);
        putLane(1, 6'd16, FLAGS_NONE, 1'b0);
        putLane(2, 6'd17, FLAGS_NONE, 1'b0);
        @(posedge clk);
        clearLanes();
        waitRetired(18);
        @(negedge clk);
        finishTest("invalidate", e);

        repeat (2) @(posedge clk);
        $display("%0d tests run, %0d with errors, %0d errors in total",
            testsRun, testsBad, errors);
        if (testsBad == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: verilog/reorderBuffer.sv
`include "rob_defines.svh"

module reorderBuffer (
    input  logic clk,
    input  logic rst,

    input  logic wbValid [`WB_WIDTH],
    input  robPkg::SqN wbSqN [`WB_WIDTH],
    input  robPkg::Flags wbFlags [`WB_WIDTH],
    input  logic [6:0] wbTag [`WB_WIDTH],
    input  logic [5:0] wbName [`WB_WIDTH],
    input  logic [31:0] wbPc [`WB_WIDTH],
    input  logic wbIsBranch [`WB_WIDTH],
    input  logic wbBranchTaken [`WB_WIDTH],
    input  robPkg::BrId wbBranchId [`WB_WIDTH],

    input  logic invalidate,
    input  robPkg::SqN invalidateSqN,
    input  logic [31:0] irqAddr,

    output robPkg::SqN curSqN,
    output robPkg::SqN maxSqN,
    output logic [31:0] retiredCount,

    output logic comValid [`COMMIT_WIDTH],
    output robPkg::SqN comSqN [`COMMIT_WIDTH],
    output logic [5:0] comName [`COMMIT_WIDTH],
    output logic [6:0] comTag [`COMMIT_WIDTH],
    output logic [31:0] comPc [`COMMIT_WIDTH],
    output logic comIsBranch [`COMMIT_WIDTH],
    output logic comBranchTaken [`COMMIT_WIDTH],
    output robPkg::BrId comBranchId [`COMMIT_WIDTH],

    output logic redirectValid,
    output logic [31:0] redirectPc,
    output robPkg::SqN redirectSqN,
    output logic halt,
    output logic fence,
    output robPkg::Flags irqFlags,
    output logic [31:0] irqSrc,
    output logic [31:0] irqMemAddr
);
    import robPkg::*;

    // head window from the entry store to commit control
    logic headValid [`COMMIT_WIDTH];
    Flags headFlags [`COMMIT_WIDTH];
    logic [5:0] headName [`COMMIT_WIDTH];
    logic [6:0] headTag [`COMMIT_WIDTH];
    logic [31:0] headPc [`COMMIT_WIDTH];
    logic headIsBranch [`COMMIT_WIDTH];
    logic headBranchTaken [`COMMIT_WIDTH];
    BrId headBranchId [`COMMIT_WIDTH];

    // slots retired this cycle, shared by the store and the head counter
    logic [1:0] commitCount;

    robEntryStore i_robEntryStore (.*);

    robHeadCounter i_robHeadCounter (.*);

    robCommitCtrl i_robCommitCtrl (.*);

endmodule

// File: rob/robCommitCtrl.sv
`include "rob_defines.svh"

module robCommitCtrl (
    input  logic clk,
    input  logic rst,
    input  logic invalidate,
    input  logic [31:0] irqAddr,
    input  robPkg::SqN curSqN,

    input  logic headValid [`COMMIT_WIDTH],
    input  robPkg::Flags headFlags [`COMMIT_WIDTH],
    input  logic [5:0] headName [`COMMIT_WIDTH],
    input  logic [6:0] headTag [`COMMIT_WIDTH],
    input  logic [31:0] headPc [`COMMIT_WIDTH],
    input  logic headIsBranch [`COMMIT_WIDTH],
    input  logic headBranchTaken [`COMMIT_WIDTH],
    input  robPkg::BrId headBranchId [`COMMIT_WIDTH],

    output logic [1:0] commitCount,

    output logic comValid [`COMMIT_WIDTH],
    output robPkg::SqN comSqN [`COMMIT_WIDTH],
    output logic [5:0] comName [`COMMIT_WIDTH],
    output logic [6:0] comTag [`COMMIT_WIDTH],
    output logic [31:0] comPc [`COMMIT_WIDTH],
    output logic comIsBranch [`COMMIT_WIDTH],
    output logic comBranchTaken [`COMMIT_WIDTH],
    output robPkg::BrId comBranchId [`COMMIT_WIDTH],

    output logic redirectValid,
    output logic [31:0] redirectPc,
    output robPkg::SqN redirectSqN,
    output logic halt,
    output logic fence,
    output robPkg::Flags irqFlags,
    output logic [31:0] irqSrc,
    output logic [31:0] irqMemAddr
);
    import robPkg::*;

    logic tripleOk;
    logic flagged;
    logic isIrq;
    logic [5:0] lane0Name;

    always_comb begin
        tripleOk = !headIsBranch[1] && !headIsBranch[2];
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            if (!headValid[i] || headFlags[i] != FLAGS_NONE) begin
                tripleOk = 1'b0;
            end
        end
        // nothing retires while a mispredict is being squashed
        if (invalidate) begin
            commitCount = 2'd0;
        end else if (tripleOk) begin
            commitCount = 2'd3;
        end else if (headValid[0]) begin
            commitCount = 2'd1;
        end else begin
            commitCount = 2'd0;
        end
    end

    // flag actions only ever happen on a single commit
    assign flagged = (commitCount == 2'd1) && (headFlags[0] != FLAGS_NONE);
    assign isIrq = (headFlags[0] == FLAGS_TRAP) || (headFlags[0] == FLAGS_EXCEPT);

    // ebreak and faulting ops must not write their destination
    assign lane0Name = (flagged && (headFlags[0] == FLAGS_BRK || headFlags[0] == FLAGS_EXCEPT))
        ? 6'd0 : headName[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                comValid[i] <= 1'b0;
            end
            redirectValid <= 1'b0;
            halt <= 1'b0;
            fence <= 1'b0;
        end else begin
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                comValid[i] <= i < int'(commitCount);
            end
            redirectValid <= flagged;
            halt <= flagged && headFlags[0] == FLAGS_BRK;
            fence <= flagged && headFlags[0] == FLAGS_FENCE;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            if (i < int'(commitCount)) begin
                comSqN[i] <= curSqN + SqN'(i);
                comName[i] <= (i == 0) ? lane0Name : headName[i];
                comTag[i] <= headTag[i];
                comPc[i] <= headPc[i];
                comIsBranch[i] <= headIsBranch[i];
                comBranchTaken[i] <= headBranchTaken[i];
                comBranchId[i] <= headBranchId[i];
            end
        end
        if (flagged) begin
            redirectSqN <= curSqN;
            // brk and fence resume at the next instruction
            redirectPc <= isIrq ? irqAddr : headPc[0] + 32'd4;
        end
        if (flagged && isIrq) begin
            irqFlags <= headFlags[0];
            irqSrc <= headPc[0];
            // faulting address segment travels in the name and branch fields
            irqMemAddr <= {7'b0, headName[0], headBranchTaken[0], headBranchId[0], 10'b0};
        end
    end

endmodule

// File: rob/robHeadCounter.sv
`include "rob_defines.svh"

module robHeadCounter (
    input  logic clk,
    input  logic rst,
    input  logic [1:0] commitCount,
    output robPkg::SqN curSqN,
    output robPkg::SqN maxSqN,
    output logic [31:0] retiredCount
);
    import robPkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            curSqN <= '0;
            retiredCount <= '0;
        end else begin
            curSqN <= curSqN + SqN'(commitCount);
            retiredCount <= retiredCount + 32'(commitCount);
        end
    end

    // youngest sqN the front end may hand out
    assign maxSqN = curSqN + SqN'(`ROB_LENGTH - 1);

    // commit control only ever retires one lane or all of them
    assert property (@(posedge clk) disable iff (rst) commitCount != 2'd2);

endmodule

// File: rob/robEntryStore.sv
`include "rob_defines.svh"

module robEntryStore (
    input  logic clk,
    input  logic rst,

    input  logic wbValid [`WB_WIDTH],
    input  robPkg::SqN wbSqN [`WB_WIDTH],
    input  robPkg::Flags wbFlags [`WB_WIDTH],
    input  logic [6:0] wbTag [`WB_WIDTH],
    input  logic [5:0] wbName [`WB_WIDTH],
    input  logic [31:0] wbPc [`WB_WIDTH],
    input  logic wbIsBranch [`WB_WIDTH],
    input  logic wbBranchTaken [`WB_WIDTH],
    input  robPkg::BrId wbBranchId [`WB_WIDTH],

    input  logic invalidate,
    input  robPkg::SqN invalidateSqN,

    input  robPkg::SqN curSqN,
    input  logic [1:0] commitCount,

    output logic headValid [`COMMIT_WIDTH],
    output robPkg::Flags headFlags [`COMMIT_WIDTH],
    output logic [5:0] headName [`COMMIT_WIDTH],
    output logic [6:0] headTag [`COMMIT_WIDTH],
    output logic [31:0] headPc [`COMMIT_WIDTH],
    output logic headIsBranch [`COMMIT_WIDTH],
    output logic headBranchTaken [`COMMIT_WIDTH],
    output robPkg::BrId headBranchId [`COMMIT_WIDTH]
);
    import robPkg::*;

    localparam int IDX_BITS = $clog2(`ROB_LENGTH);

    RobEntry entries [`ROB_LENGTH];
    logic [IDX_BITS-1:0] headIdx [`COMMIT_WIDTH];
    logic wbKeep [`WB_WIDTH];

    // true when a was issued after b
    function automatic logic isYounger(input SqN a, input SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

    // writebacks of squashed instructions are dropped
    always_comb begin
        for (int i = 0; i < `WB_WIDTH; i++) begin
            wbKeep[i] = wbValid[i] && !(invalidate && isYounger(wbSqN[i], invalidateSqN));
        end
    end

    always_comb begin
        RobEntry slot;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            headIdx[i] = curSqN[IDX_BITS-1:0] + IDX_BITS'(i);
            slot = entries[headIdx[i]];
            headValid[i] = slot.valid;
            headFlags[i] = slot.flags;
            headName[i] = slot.name;
            headTag[i] = slot.tag;
            headPc[i] = {slot.pc, 1'b0};
            headIsBranch[i] = slot.isBranch;
            headBranchTaken[i] = slot.branchTaken;
            headBranchId[i] = slot.branchId;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ROB_LENGTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            // squash everything younger than the mispredicted branch
            if (invalidate) begin
                for (int i = 0; i < `ROB_LENGTH; i++) begin
                    if (isYounger(entries[i].sqN, invalidateSqN)) begin
                        entries[i].valid <= 1'b0;
                    end
                end
            end
            // free the slots retiring at this edge
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                if (i < int'(commitCount)) begin
                    entries[headIdx[i]].valid <= 1'b0;
                end
            end
            for (int i = 0; i < `WB_WIDTH; i++) begin
                if (wbKeep[i]) begin
                    entries[wbSqN[i][IDX_BITS-1:0]] <= '{
                        valid: 1'b1,
                        flags: wbFlags[i],
                        tag: wbTag[i],
                        sqN: wbSqN[i],
                        pc: wbPc[i][31:1],
                        name: wbName[i],
                        isBranch: wbIsBranch[i],
                        branchTaken: wbBranchTaken[i],
                        branchId: wbBranchId[i]
                    };
                end
            end
        end
    end

    // the producer stays within maxSqN, so a slot is never overwritten while live
    for (genvar g = 0; g < `WB_WIDTH; g++) begin : gWbCheck
        assert property (@(posedge clk) disable iff (rst)
            wbKeep[g] |-> !entries[wbSqN[g][IDX_BITS-1:0]].valid);
    end

endmodule

// File: common/robPkg.sv
`include "rob_defines.svh"

package robPkg;

    // special handling requested by the execution units
    typedef enum logic [2:0] {
        FLAGS_NONE,
        FLAGS_BRK,
        FLAGS_TRAP,
        FLAGS_EXCEPT,
        FLAGS_FENCE
    } Flags;

    // sequence number, compare ages through the signed difference
    typedef logic [`SQN_BITS-1:0] SqN;

    typedef logic [`BRID_BITS-1:0] BrId;

    typedef struct packed {
        logic valid;
        Flags flags;
        logic [6:0] tag;
        // kept per slot so invalidate can compare ages
        SqN sqN;
        // bit 0 of the pc is always zero and not stored
        logic [30:0] pc;
        logic [5:0] name;
        logic isBranch;
        logic branchTaken;
        BrId branchId;
    } RobEntry;

endpackage

// File: common/rob_defines.svh
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// reorder buffer geometry
`define ROB_LENGTH 32
`define COMMIT_WIDTH 3
`define WB_WIDTH 3

// sqN carries one bit more than the slot index for wraparound age compares
`define SQN_BITS 6
`define BRID_BITS 8

`endif
